// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// --------------------------------------------------
// Core dimensions
// --------------------------------------------------

// Data path, register and APB address width
`define CPU_WORD_W 16

// General registers
`define CPU_NREGS 8

// First fetch address after start
`define CPU_RESET_PC 16'h0000

`endif

// File: common/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

	// Instruction codes in ir[15:12], the rest are illegal
	typedef enum logic [3:0] {
		OP_LW  = 4'h0,
		OP_SW  = 4'h1,
		OP_LWT = 4'h2,
		OP_ADD = 4'h3,
		OP_SUB = 4'h4,
		OP_AND = 4'h5,
		OP_OR  = 4'h6,
		OP_XOR = 4'h7,
		OP_SHR = 4'h8,
		OP_JMP = 4'h9,
		OP_JZ  = 4'ha,
		OP_JC  = 4'hb,
		OP_HLT = 4'hc
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHR
	} alu_op_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_DECODE,
		S_EXECUTE,
		S_MEMORY,
		S_WRITEBACK,
		S_HALTED
	} seq_state_e;

	// Jump condition
	typedef enum logic [1:0] {
		BR_NONE,
		BR_JMP,
		BR_JZ,
		BR_JC
	} branch_e;

	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

endpackage

// File: hw/cycle_control.sv
`include "cpu_defines.svh"

module cycle_control import cpu_pkg::*; #(
	parameter bit STOP_ON_BUS_ERROR = 1'b1
) (
	input  logic                   __clk,
	input  logic                   rst_n,
	input  logic                   start,

	// Bus master response
	input  logic                   bus_done,
	input  logic                   bus_err,
	input  logic [`CPU_WORD_W-1:0] bus_rdata,

	// Decoder
	input  logic                   mem_rd,
	input  logic                   mem_wr,
	input  logic                   illegal,
	input  logic                   is_halt,

	// Execute
	input  logic                   take_branch,
	input  logic [`CPU_WORD_W-1:0] branch_target,

	// Bus request
	output logic                   bus_req,
	output logic                   bus_we,
	output logic [`CPU_WORD_W-1:0] bus_addr,

	// Decoder and writeback
	output logic [`CPU_WORD_W-1:0] ir,
	output logic                   wb_en,
	output logic [`CPU_WORD_W-1:0] load_data,
	output logic                   load_sel,

	output logic                   run,
	output logic                   halt,
	output logic                   alarm
);

	localparam logic [`CPU_WORD_W-1:0] RESET_PC = `CPU_RESET_PC;

	seq_state_e             state, state_nxt;
	logic [`CPU_WORD_W-1:0] pc;
	logic [`CPU_WORD_W-1:0] rdata_ok;
	logic                   bus_fault;
	logic                   alarm_now;

	// Failed transfer stops the core only when configured to
	assign bus_fault = bus_done && bus_err && STOP_ON_BUS_ERROR;
	// Erroring reads return zero
	assign rdata_ok  = bus_err ? '0 : bus_rdata;
	assign alarm_now = bus_fault || (state == S_DECODE && illegal);

	// --------------------------------------------------
	// Next state
	// --------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (start)
					state_nxt = S_FETCH;
			end
			S_FETCH: begin
				if (bus_fault)
					state_nxt = S_HALTED;
				else if (bus_done)
					state_nxt = S_DECODE;
			end
			S_DECODE: begin
				if (illegal || is_halt)
					state_nxt = S_HALTED;
				else
					state_nxt = S_EXECUTE;
			end
			S_EXECUTE: begin
				if (mem_rd || mem_wr)
					state_nxt = S_MEMORY;
				else
					state_nxt = S_WRITEBACK;
			end
			S_MEMORY: begin
				if (bus_fault)
					state_nxt = S_HALTED;
				else if (bus_done)
					state_nxt = S_WRITEBACK;
			end
			S_WRITEBACK: state_nxt = S_FETCH;
			S_HALTED:    state_nxt = S_HALTED;
			default:     state_nxt = S_HALTED;
		endcase
	end

	// Request goes out in the cycle before fetch or memory so APB setup
	// lines up with the first cycle of that state
	assign bus_req  = (state == S_IDLE && start) || state == S_WRITEBACK ||
		(state == S_EXECUTE && (mem_rd || mem_wr));
	assign bus_we   = (state == S_EXECUTE) && mem_wr;
	assign bus_addr = (state == S_EXECUTE) ? branch_target : pc;

	assign wb_en    = (state == S_WRITEBACK);
	assign load_sel = mem_rd;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			pc    <= RESET_PC;
			ir    <= '0;
			run   <= 1'b0;
			halt  <= 1'b0;
			alarm <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == S_IDLE && start)
				run <= 1'b1;
			if (state == S_FETCH && bus_done) begin
				ir <= rdata_ok;
				pc <= pc + 1'b1;
			end
			// Jumps redirect before the next fetch is requested
			if (state == S_EXECUTE && take_branch)
				pc <= branch_target;
			if (state_nxt == S_HALTED && state != S_HALTED) begin
				run   <= 1'b0;
				halt  <= 1'b1;
				alarm <= alarm_now;
			end
		end
	end

	// Load result, held until writeback
	always_ff @(posedge __clk) begin
		if (state == S_MEMORY && bus_done)
			load_data <= rdata_ok;
	end

	a_no_req_halted: assert property (@(posedge __clk) disable iff (!rst_n)
		halt |-> !bus_req);

	a_wb_one_cycle: assert property (@(posedge __clk) disable iff (!rst_n)
		wb_en |=> !wb_en);

endmodule

// File: hw/instr_decoder.sv
`include "cpu_defines.svh"

module instr_decoder import cpu_pkg::*; (
	input  logic [`CPU_WORD_W-1:0] ir,
	output alu_op_e                op,
	output reg_idx_t               ra,
	output reg_idx_t               rb,
	output logic [`CPU_WORD_W-1:0] imm,
	output logic                   mem_rd,
	output logic                   mem_wr,
	output logic                   alu_wb,
	output logic                   set_carry,
	output branch_e                branch_kind,
	output logic                   is_halt,
	output logic                   illegal
);

	localparam int ARG_W = 9;

	opcode_e          opcode;
	logic [ARG_W-1:0] arg;

	assign opcode = opcode_e'(ir[15:12]);
	assign ra     = ir[11:9];
	assign arg    = ir[ARG_W-1:0];
	// Second operand register sits in the low argument bits
	assign rb     = arg[2:0];

	// LWT takes a signed constant, everything else an unsigned address
	assign imm = (opcode == OP_LWT) ?
		{{(`CPU_WORD_W-ARG_W){arg[ARG_W-1]}}, arg} :
		{{(`CPU_WORD_W-ARG_W){1'b0}}, arg};

	always_comb begin
		op          = ALU_PASS;
		mem_rd      = 1'b0;
		mem_wr      = 1'b0;
		alu_wb      = 1'b0;
		set_carry   = 1'b0;
		branch_kind = BR_NONE;
		is_halt     = 1'b0;
		illegal     = 1'b0;
		case (opcode)
			OP_LW:  mem_rd = 1'b1;
			OP_SW:  mem_wr = 1'b1;
			OP_LWT: alu_wb = 1'b1;
			OP_ADD: begin
				op        = ALU_ADD;
				alu_wb    = 1'b1;
				set_carry = 1'b1;
			end
			OP_SUB: begin
				op        = ALU_SUB;
				alu_wb    = 1'b1;
				set_carry = 1'b1;
			end
			OP_AND: begin
				op     = ALU_AND;
				alu_wb = 1'b1;
			end
			OP_OR: begin
				op     = ALU_OR;
				alu_wb = 1'b1;
			end
			OP_XOR: begin
				op     = ALU_XOR;
				alu_wb = 1'b1;
			end
			OP_SHR: begin
				op        = ALU_SHR;
				alu_wb    = 1'b1;
				set_carry = 1'b1;
			end
			OP_JMP: branch_kind = BR_JMP;
			OP_JZ:  branch_kind = BR_JZ;
			OP_JC:  branch_kind = BR_JC;
			OP_HLT: is_halt = 1'b1;
			default: illegal = 1'b1;
		endcase
	end

endmodule

// File: hw/alu_exec.sv
`include "cpu_defines.svh"

module alu_exec import cpu_pkg::*; (
	input  logic                   __clk,
	input  logic                   rst_n,

	// Operands and controls
	input  alu_op_e                op,
	input  logic [`CPU_WORD_W-1:0] a,
	input  logic [`CPU_WORD_W-1:0] b,
	input  logic [`CPU_WORD_W-1:0] imm,
	input  logic                   set_carry,
	input  branch_e                branch_kind,
	input  logic                   z_flag,
	input  logic                   c_flag,

	// Results
	output logic [`CPU_WORD_W-1:0] result,
	output logic                   carry_out,
	output logic                   zero_out,
	output logic                   take_branch,
	output logic [`CPU_WORD_W-1:0] branch_target
);

	logic [`CPU_WORD_W-1:0] res_nxt;
	logic                   carry_nxt;

	// --------------------------------------------------
	// Arithmetic and logic
	// --------------------------------------------------
	always_comb begin
		res_nxt   = imm;
		carry_nxt = 1'b0;
		case (op)
			ALU_ADD: {carry_nxt, res_nxt} = {1'b0, a} + {1'b0, b};
			// Carry is the borrow out of the subtraction
			ALU_SUB: {carry_nxt, res_nxt} = {1'b0, a} - {1'b0, b};
			ALU_AND: res_nxt = a & b;
			ALU_OR:  res_nxt = a | b;
			ALU_XOR: res_nxt = a ^ b;
			ALU_SHR: begin
				res_nxt   = a >> 1;
				carry_nxt = a[0];
			end
			default: res_nxt = imm;
		endcase
		// Logic ops leave C as it was
		if (!set_carry)
			carry_nxt = c_flag;
	end

	// Operands hold still from decode to writeback, so the result
	// captured at the end of execute stays valid until it is written
	always_ff @(posedge __clk) begin
		result <= res_nxt;
	end

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			carry_out <= 1'b0;
			zero_out  <= 1'b0;
		end else begin
			carry_out <= carry_nxt;
			zero_out  <= (res_nxt == '0);
		end
	end

	// --------------------------------------------------
	// Branch decision
	// --------------------------------------------------
	always_comb begin
		case (branch_kind)
			BR_JMP:  take_branch = 1'b1;
			BR_JZ:   take_branch = z_flag;
			BR_JC:   take_branch = c_flag;
			default: take_branch = 1'b0;
		endcase
	end

	// Also the LW and SW address
	assign branch_target = {{(`CPU_WORD_W-9){1'b0}}, imm[8:0]};

endmodule

// File: hw/reg_writeback.sv
`include "cpu_defines.svh"

module reg_writeback import cpu_pkg::*; (
	input  logic                   __clk,
	input  logic                   rst_n,
	input  logic                   wb_en,

	// Write selection and data
	input  reg_idx_t               wr_idx,
	input  logic                   load_sel,
	input  logic [`CPU_WORD_W-1:0] load_data,
	input  logic [`CPU_WORD_W-1:0] alu_result,
	input  logic                   alu_carry,
	input  logic                   alu_zero,
	input  logic                   set_carry,
	input  logic                   set_zero,

	// Reads
	input  reg_idx_t               rd_a_idx,
	input  reg_idx_t               rd_b_idx,
	output logic [`CPU_WORD_W-1:0] rd_a,
	output logic [`CPU_WORD_W-1:0] rd_b,
	output logic                   z_flag,
	output logic                   c_flag
);

	logic [`CPU_WORD_W-1:0] regs [`CPU_NREGS];
	logic                   reg_we;

	// Jumps and stores pass writeback without touching ra
	assign reg_we = wb_en && (load_sel || set_zero);

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			regs   <= '{default: '0};
			z_flag <= 1'b0;
			c_flag <= 1'b0;
		end else begin
			if (reg_we)
				regs[wr_idx] <= load_sel ? load_data : alu_result;
			if (wb_en && set_zero)
				z_flag <= alu_zero;
			if (wb_en && set_carry)
				c_flag <= alu_carry;
		end
	end

	assign rd_a = regs[rd_a_idx];
	assign rd_b = regs[rd_b_idx];

	a_wr_idx_known: assert property (@(posedge __clk) disable iff (!rst_n)
		wb_en |-> !$isunknown(wr_idx));

endmodule

// File: hw/apb_master.sv
`include "cpu_defines.svh"

module apb_master (
	input  logic                   __clk,
	input  logic                   rst_n,

	// Request side
	input  logic                   req,
	input  logic                   we,
	input  logic [`CPU_WORD_W-1:0] addr,
	input  logic [`CPU_WORD_W-1:0] wdata,
	output logic                   done,
	output logic [`CPU_WORD_W-1:0] rdata,
	output logic                   err,

	// APB side
	output logic [`CPU_WORD_W-1:0] paddr,
	output logic                   psel,
	output logic                   penable,
	output logic                   pwrite,
	output logic [`CPU_WORD_W-1:0] pwdata,
	input  logic [`CPU_WORD_W-1:0] prdata,
	input  logic                   pready,
	input  logic                   pslverr
);

	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_e;

	apb_state_e state;

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= APB_IDLE;
			pwrite <= 1'b0;
		end else begin
			case (state)
				APB_IDLE: begin
					if (req) begin
						state  <= APB_SETUP;
						pwrite <= we;
					end
				end
				APB_SETUP: state <= APB_ACCESS;
				// Wait states keep everything where it is
				APB_ACCESS: begin
					if (pready)
						state <= APB_IDLE;
				end
				default: state <= APB_IDLE;
			endcase
		end
	end

	// Address and data captured once per transfer
	always_ff @(posedge __clk) begin
		if (state == APB_IDLE && req) begin
			paddr  <= addr;
			pwdata <= wdata;
		end
	end

	assign psel    = (state != APB_IDLE);
	assign penable = (state == APB_ACCESS);

	assign done  = penable && pready;
	assign rdata = prdata;
	assign err   = done && pslverr;

	// Access phase always follows a setup cycle
	a_penable_psel: assert property (@(posedge __clk) disable iff (!rst_n)
		penable |-> psel && $past(psel));

	a_paddr_stable: assert property (@(posedge __clk) disable iff (!rst_n)
		psel && $past(psel) |-> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

// File: hw/cpu.sv
`include "cpu_defines.svh"

module cpu import cpu_pkg::*; #(
	parameter bit STOP_ON_BUS_ERROR = 1'b1
) (
	input  logic                   __clk,
	input  logic                   rst_n,
	input  logic                   start,

	// APB master
	output logic [`CPU_WORD_W-1:0] paddr,
	output logic                   psel,
	output logic                   penable,
	output logic                   pwrite,
	output logic [`CPU_WORD_W-1:0] pwdata,
	input  logic [`CPU_WORD_W-1:0] prdata,
	input  logic                   pready,
	input  logic                   pslverr,

	// Status
	output logic                   run,
	output logic                   halt,
	output logic                   alarm
);

	// Sequencer and bus master
	logic                   bus_req, bus_we, bus_done, bus_err;
	logic [`CPU_WORD_W-1:0] bus_addr, bus_rdata;
	logic [`CPU_WORD_W-1:0] ir, load_data;
	logic                   wb_en, load_sel;

	// Decoded instruction
	alu_op_e                op;
	reg_idx_t               ra, rb;
	logic [`CPU_WORD_W-1:0] imm;
	logic                   mem_rd, mem_wr, alu_wb, set_carry;
	branch_e                branch_kind;
	logic                   is_halt, illegal;

	// Data path
	logic [`CPU_WORD_W-1:0] rd_a, rd_b, alu_result, branch_target;
	logic                   z_flag, c_flag, alu_carry, alu_zero, take_branch;

	// --------------------------------------------------
	cycle_control #(.STOP_ON_BUS_ERROR(STOP_ON_BUS_ERROR)) i_cycle_control (
		.__clk(__clk), .rst_n(rst_n), .start(start),
		.bus_done(bus_done), .bus_err(bus_err), .bus_rdata(bus_rdata),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .illegal(illegal), .is_halt(is_halt),
		.take_branch(take_branch), .branch_target(branch_target),
		.bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr),
		.ir(ir), .wb_en(wb_en), .load_data(load_data), .load_sel(load_sel),
		.run(run), .halt(halt), .alarm(alarm)
	);

	instr_decoder i_instr_decoder (
		.ir(ir), .op(op), .ra(ra), .rb(rb), .imm(imm),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .alu_wb(alu_wb), .set_carry(set_carry),
		.branch_kind(branch_kind), .is_halt(is_halt), .illegal(illegal)
	);

	alu_exec i_alu_exec (
		.__clk(__clk), .rst_n(rst_n),
		.op(op), .a(rd_a), .b(rd_b), .imm(imm), .set_carry(set_carry),
		.branch_kind(branch_kind), .z_flag(z_flag), .c_flag(c_flag),
		.result(alu_result), .carry_out(alu_carry), .zero_out(alu_zero),
		.take_branch(take_branch), .branch_target(branch_target)
	);

	// ALU writes to ra are also the ones that update Z
	reg_writeback i_reg_writeback (
		.__clk(__clk), .rst_n(rst_n), .wb_en(wb_en),
		.wr_idx(ra), .load_sel(load_sel), .load_data(load_data),
		.alu_result(alu_result), .alu_carry(alu_carry), .alu_zero(alu_zero),
		.set_carry(set_carry), .set_zero(alu_wb),
		.rd_a_idx(ra), .rd_b_idx(rb), .rd_a(rd_a), .rd_b(rd_b),
		.z_flag(z_flag), .c_flag(c_flag)
	);

	// Store data comes straight from ra
	apb_master i_apb_master (
		.__clk(__clk), .rst_n(rst_n),
		.req(bus_req), .we(bus_we), .addr(bus_addr), .wdata(rd_a),
		.done(bus_done), .rdata(bus_rdata), .err(bus_err),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

endmodule

// File: dv/apb_mem_model.sv
`include "cpu_defines.svh"

module apb_mem_model #(
	parameter logic [`CPU_WORD_W-1:0] ERR_ADDR = 16'h01f0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_WORD_W-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`CPU_WORD_W-1:0] pwdata,
	output logic [`CPU_WORD_W-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH = 512;

	logic [`CPU_WORD_W-1:0] mem [DEPTH];
	logic [1:0]             wait_cnt;
	logic [1:0]             waits;
	logic [8:0]             idx;
	logic                   hit_err;
	integer                 seed = 32'h58f4_b1ef;

	assign idx     = paddr[8:0];
	assign hit_err = (paddr == ERR_ADDR);

	// --------------------------------------------------
	// Slave timing, 0 to 3 wait cycles per transfer
	// --------------------------------------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pready   <= 1'b0;
			pslverr  <= 1'b0;
			prdata   <= '0;
			wait_cnt <= '0;
		end else if (psel && !penable) begin
			// Setup phase draws the wait count
			waits = 2'($random(seed));
			wait_cnt <= waits;
			pready   <= (waits == 2'd0);
			pslverr  <= (waits == 2'd0) && hit_err;
			prdata   <= mem[idx];
		end else if (psel && penable && !pready) begin
			wait_cnt <= wait_cnt - 2'd1;
			pready   <= (wait_cnt == 2'd1);
			pslverr  <= (wait_cnt == 2'd1) && hit_err;
			prdata   <= mem[idx];
		end else begin
			// Last access cycle or idle bus
			if (psel && penable && pwrite && !hit_err)
				mem[idx] <= pwdata;
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end
	end

	// Background is an illegal opcode carrying the whole address
	task automatic fill();
		for (int i = 0; i < DEPTH; i++)
			mem[i] <= 16'hf000 | 16'(i);
	endtask

	task automatic write_word(input logic [`CPU_WORD_W-1:0] addr,
		input logic [`CPU_WORD_W-1:0] data);
		mem[addr[8:0]] <= data;
	endtask

endmodule

// File: dv/tb_cpu.sv
`include "cpu_defines.svh"

module tb_cpu import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TESTS       = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 400;
	localparam int MAX_STORES      = 16;
	localparam logic [`CPU_WORD_W-1:0] ERR_ADDR = 16'h01f0;

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	logic [`CPU_WORD_W-1:0] paddr, pwdata, prdata;
	logic                   psel, penable, pwrite, pready, pslverr;
	logic                   run, halt, alarm;

	// Expected stores in program order
	logic [`CPU_WORD_W-1:0] exp_addr [MAX_STORES];
	logic [`CPU_WORD_W-1:0] exp_data [MAX_STORES];
	logic [`CPU_WORD_W-1:0] exp_addr_now, exp_data_now;
	int                     exp_count = 0;
	int                     store_idx;
	logic                   exp_alarm = 1'b0;

	logic                   pre_start, first_req, wr_done;
	logic [`CPU_WORD_W-1:0] load_pc;
	int                     error_count = 0;
	int                     tests_run = 0;
	int                     tests_failed = 0;
	int                     errors_before;

	cpu i_dut (
		.__clk(clk), .rst_n(rst_n), .start(start),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.run(run), .halt(halt), .alarm(alarm)
	);

	apb_mem_model #(.ERR_ADDR(ERR_ADDR)) i_mem (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles without the tests finishing", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// --------------------------------------------------
	// Trackers for the checks
	// --------------------------------------------------
	assign wr_done = psel && penable && pready && pwrite;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_start <= 1'b1;
			first_req <= 1'b0;
			store_idx <= 0;
		end else begin
			if (start) begin
				pre_start <= 1'b0;
				first_req <= 1'b1;
			end else if (psel)
				first_req <= 1'b0;
			if (wr_done)
				store_idx <= store_idx + 1;
		end
	end

	always_comb begin
		exp_addr_now = '0;
		exp_data_now = '0;
		if (store_idx < exp_count) begin
			exp_addr_now = exp_addr[store_idx[3:0]];
			exp_data_now = exp_data[store_idx[3:0]];
		end
	end

	// --------------------------------------------------
	// Assertions
	// --------------------------------------------------
	a_quiet_before_start: assert property (@(posedge clk) disable iff (!rst_n)
		pre_start |-> !psel && !penable && !run && !halt && !alarm)
		else begin
			error_count++;
			$display("bus or status outputs went active before start");
		end

	a_first_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		first_req && psel |-> paddr == `CPU_RESET_PC)
		else begin
			error_count++;
			$display("mismatch paddr: got 0x%h, expected 0x%h on the first fetch",
				$sampled(paddr), `CPU_RESET_PC);
		end

	a_setup_first: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(psel) |-> !penable)
		else begin
			error_count++;
			$display("penable rose together with psel");
		end

	a_access_follows: assert property (@(posedge clk) disable iff (!rst_n)
		psel && !penable |=> psel && penable)
		else begin
			error_count++;
			$display("penable did not follow psel by one cycle");
		end

	a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> psel)
		else begin
			error_count++;
			$display("penable high without psel");
		end

	a_hold_until_ready: assert property (@(posedge clk) disable iff (!rst_n)
		psel && !(penable && pready) |=>
			psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else begin
			error_count++;
			$display("APB transfer dropped or changed before pready");
		end

	a_drop_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
		psel && penable && pready |=> !psel && !penable)
		else begin
			error_count++;
			$display("psel and penable did not drop together after pready");
		end

	a_store_expected: assert property (@(posedge clk) disable iff (!rst_n)
		wr_done |-> store_idx < exp_count)
		else begin
			error_count++;
			$display("unexpected store to address 0x%h with data 0x%h",
				$sampled(paddr), $sampled(pwdata));
		end

	a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
		wr_done && store_idx < exp_count |-> paddr == exp_addr_now)
		else begin
			error_count++;
			$display("mismatch paddr: got 0x%h, expected 0x%h",
				$sampled(paddr), $sampled(exp_addr_now));
		end

	a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
		wr_done && store_idx < exp_count |-> pwdata == exp_data_now)
		else begin
			error_count++;
			$display("mismatch pwdata: got 0x%h, expected 0x%h",
				$sampled(pwdata), $sampled(exp_data_now));
		end

	// Bus traffic only while the core runs
	a_run_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		psel |-> run)
		else begin
			error_count++;
			$display("APB transfer while run is low");
		end

	// Stopped core stays off the bus
	a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		halt |-> !psel && !penable && !run ##1 halt)
		else begin
			error_count++;
			$display("bus activity or run seen while halted, or halt dropped");
		end

	a_alarm_value: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(halt) |-> alarm == exp_alarm)
		else begin
			error_count++;
			$display("mismatch alarm: got 0x%h, expected 0x%h", $sampled(alarm), exp_alarm);
		end

	a_alarm_halts: assert property (@(posedge clk) disable iff (!rst_n)
		alarm |-> halt)
		else begin
			error_count++;
			$display("alarm raised without halt");
		end

	// --------------------------------------------------
	// Program building and test flow
	// --------------------------------------------------
	function automatic logic [`CPU_WORD_W-1:0] sext9(input logic [8:0] v);
		return {{(`CPU_WORD_W-9){v[8]}}, v};
	endfunction

	task automatic emit(input opcode_e op, input reg_idx_t ra, input logic [8:0] arg);
		i_mem.write_word(load_pc, {op, ra, arg});
		load_pc = load_pc + 16'd1;
	endtask

	task automatic put_word(input logic [`CPU_WORD_W-1:0] word);
		i_mem.write_word(load_pc, word);
		load_pc = load_pc + 16'd1;
	endtask

	task automatic expect_store(input logic [`CPU_WORD_W-1:0] addr,
		input logic [`CPU_WORD_W-1:0] data);
		exp_addr[exp_count] = addr;
		exp_data[exp_count] = data;
		exp_count++;
	endtask

	task automatic prepare_run();
		@(posedge clk);
		rst_n <= 1'b0;
		i_mem.fill();
		load_pc = `CPU_RESET_PC;
		exp_count = 0;
		exp_alarm = 1'b0;
		errors_before = error_count;
	endtask

	task automatic run_program(input int idle_cycles);
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (idle_cycles) @(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		do @(negedge clk); while (!halt);
		// Some halted cycles so the quiet-bus check gets exercised
		repeat (10) @(negedge clk);
	endtask

	task automatic report_result(input string name);
		assert (store_idx == exp_count) else begin
			error_count++;
			$display("%s: %0d of %0d expected stores reached the bus",
				name, store_idx, exp_count);
		end
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic reset_and_start();
		prepare_run();
		emit(OP_HLT, 3'd0, 9'd0);
		run_program(20);
		report_result("reset_and_start");
	endtask

	task automatic apb_traffic();
		prepare_run();
		emit(OP_LWT, 3'd1, 9'h055);
		emit(OP_SW, 3'd1, 9'h120);
		expect_store(16'h0120, sext9(9'h055));
		emit(OP_LW, 3'd2, 9'h120);
		emit(OP_SW, 3'd2, 9'h121);
		expect_store(16'h0121, sext9(9'h055));
		emit(OP_LW, 3'd3, 9'h130);
		emit(OP_SW, 3'd3, 9'h131);
		expect_store(16'h0131, 16'hbeef);
		emit(OP_LWT, 3'd4, 9'h1ff);
		emit(OP_SW, 3'd4, 9'h132);
		expect_store(16'h0132, sext9(9'h1ff));
		emit(OP_HLT, 3'd0, 9'd0);
		i_mem.write_word(16'h0130, 16'hbeef);
		run_program(5);
		report_result("apb_traffic");
	endtask

	task automatic arithmetic_stores();
		logic [`CPU_WORD_W-1:0] a;
		logic [`CPU_WORD_W-1:0] b;
		prepare_run();
		a = sext9(9'h0f3);
		b = sext9(9'h1a5);
		emit(OP_LWT, 3'd2, 9'h1a5);
		emit(OP_SW, 3'd2, 9'h147);
		expect_store(16'h0147, b);
		// Each result register is reloaded with a, then combined with r2
		emit(OP_LWT, 3'd3, 9'h0f3);
		emit(OP_ADD, 3'd3, 9'd2);
		emit(OP_SW, 3'd3, 9'h140);
		expect_store(16'h0140, a + b);
		emit(OP_LWT, 3'd4, 9'h0f3);
		emit(OP_SUB, 3'd4, 9'd2);
		emit(OP_SW, 3'd4, 9'h141);
		expect_store(16'h0141, a - b);
		emit(OP_LWT, 3'd5, 9'h0f3);
		emit(OP_AND, 3'd5, 9'd2);
		emit(OP_SW, 3'd5, 9'h142);
		expect_store(16'h0142, a & b);
		emit(OP_LWT, 3'd6, 9'h0f3);
		emit(OP_OR, 3'd6, 9'd2);
		emit(OP_SW, 3'd6, 9'h143);
		expect_store(16'h0143, a | b);
		emit(OP_LWT, 3'd7, 9'h0f3);
		emit(OP_XOR, 3'd7, 9'd2);
		emit(OP_SW, 3'd7, 9'h144);
		expect_store(16'h0144, a ^ b);
		emit(OP_LWT, 3'd1, 9'h0f3);
		emit(OP_SHR, 3'd1, 9'd0);
		emit(OP_SW, 3'd1, 9'h145);
		expect_store(16'h0145, a >> 1);
		emit(OP_HLT, 3'd0, 9'd0);
		run_program(5);
		report_result("arithmetic_stores");
	endtask

	task automatic branch_paths();
		prepare_run();
		emit(OP_LWT, 3'd1, 9'd5);
		emit(OP_LWT, 3'd2, 9'd5);
		emit(OP_SUB, 3'd1, 9'd2);
		emit(OP_JZ, 3'd0, 9'd5);
		emit(OP_SW, 3'd2, 9'h150);
		// Address 5, JZ target
		emit(OP_SW, 3'd2, 9'h151);
		expect_store(16'h0151, 16'd5);
		emit(OP_LWT, 3'd3, 9'd1);
		emit(OP_ADD, 3'd3, 9'd3);
		emit(OP_JC, 3'd0, 9'd14);
		emit(OP_SW, 3'd3, 9'h152);
		expect_store(16'h0152, 16'd2);
		emit(OP_JMP, 3'd0, 9'd12);
		emit(OP_SW, 3'd3, 9'h153);
		// Address 12, JMP target
		emit(OP_SW, 3'd1, 9'h154);
		expect_store(16'h0154, 16'd0);
		emit(OP_HLT, 3'd0, 9'd0);
		// Address 14, reached only by a wrong JC
		emit(OP_SW, 3'd3, 9'h15f);
		emit(OP_HLT, 3'd0, 9'd0);
		run_program(5);
		report_result("branch_paths");
	endtask

	task automatic bus_error_stop();
		prepare_run();
		exp_alarm = 1'b1;
		emit(OP_LWT, 3'd1, 9'd7);
		emit(OP_SW, 3'd1, 9'h160);
		expect_store(16'h0160, 16'd7);
		emit(OP_LW, 3'd2, ERR_ADDR[8:0]);
		emit(OP_SW, 3'd2, 9'h161);
		emit(OP_HLT, 3'd0, 9'd0);
		run_program(5);
		report_result("bus_error_stop");
	endtask

	task automatic illegal_opcode_stop();
		prepare_run();
		exp_alarm = 1'b1;
		emit(OP_LWT, 3'd1, 9'd3);
		emit(OP_SW, 3'd1, 9'h170);
		expect_store(16'h0170, 16'd3);
		put_word(16'hd000);
		emit(OP_SW, 3'd1, 9'h171);
		emit(OP_HLT, 3'd0, 9'd0);
		run_program(5);
		report_result("illegal_opcode_stop");
	endtask

	initial begin
		rst_n <= 1'b0;
		start <= 1'b0;
		reset_and_start();
		apb_traffic();
		arithmetic_stores();
		branch_paths();
		bus_error_stop();
		illegal_opcode_stop();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: cpu_core.f
+incdir+common
common/cpu_pkg.sv
hw/cycle_control.sv
hw/instr_decoder.sv
hw/alu_exec.sv
hw/reg_writeback.sv
hw/apb_master.sv
hw/cpu.sv
dv/apb_mem_model.sv
dv/tb_cpu.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - hw/cycle_control.sv
      - hw/instr_decoder.sv
      - hw/alu_exec.sv
      - hw/reg_writeback.sv
      - hw/apb_master.sv
      - hw/cpu.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/apb_mem_model.sv
      - dv/tb_cpu.sv
